// ==== verilog/core_pkg.sv ====
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;
    typedef word_t [31:0] regfile_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_COPY2
    } alu_fn_t;

    typedef enum logic [1:0] {
        BR_X,
        BR_BEQ,
        BR_BNE,
        BR_JAL
    } br_fn_t;

    typedef enum logic [1:0] {
        MEN_X,
        MEN_LW,
        MEN_SW
    } mem_fn_t;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_t;

    typedef struct packed {
        alu_fn_t   alu_fn;
        br_fn_t    br_fn;
        mem_fn_t   mem_fn;
        wb_sel_t   wb_sel;
        logic      rf_wen;
        reg_addr_t wb_addr;
        logic      is_exit;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
    } if_id_t;

    // op2 holds the immediate for loads, stores, branches and jal
    typedef struct packed {
        logic  valid;
        word_t pc;
        ctrl_t ctrl;
        word_t op1;
        word_t op2;
        word_t rs2_data;
    } id_exe_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        ctrl_t ctrl;
        word_t alu_out;
        word_t rs2_data;
    } exe_mem_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        ctrl_t ctrl;
        word_t alu_out;
        word_t mem_rdata;
    } mem_wb_t;

    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam word_t reset_pc = 32'h0000_0000;
    // addi x0, x0, 0
    localparam word_t nop_inst = 32'h0000_0013;

endpackage

// ==== verilog/fetch_stage.sv ====
module fetch_stage (
    input  logic             clk,
    input  logic             rst_n,
    output logic             memory_inst_start,
    input  logic             memory_inst_ready,
    output core_pkg::word_t  memory_i_addr,
    input  core_pkg::word_t  memory_inst,
    input  logic             memory_inst_valid,
    output core_pkg::if_id_t if_id,
    input  logic             stall,
    input  logic             branch_taken,
    input  core_pkg::word_t  branch_target,
    input  logic             halt
);
    import core_pkg::*;

    word_t pc;
    word_t skid_inst;
    logic  pending;
    logic  stale;
    logic  skid_valid;
    logic  reply;
    logic  fresh;
    logic  issue;

    assign reply = pending && memory_inst_valid;
    // replies to a request made before a redirect are dropped
    assign fresh = reply && !stale;
    assign issue = !memory_inst_start && !pending && !skid_valid && !halt && !branch_taken;

    // no new request while a word sits in the skid, so the address is still its pc
    always_comb begin
        if_id.valid = !branch_taken && (skid_valid || fresh);
        if_id.pc    = memory_i_addr;
        if (skid_valid) begin
            if_id.inst = skid_inst;
        end else if (fresh) begin
            if_id.inst = memory_inst;
        end else begin
            if_id.inst = nop_inst;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc                <= reset_pc;
            memory_i_addr     <= reset_pc;
            memory_inst_start <= 1'b0;
            pending           <= 1'b0;
            stale             <= 1'b0;
            skid_valid        <= 1'b0;
        end else begin
            if (memory_inst_start && memory_inst_ready) begin
                memory_inst_start <= 1'b0;
                pending           <= 1'b1;
            end else if (issue) begin
                memory_inst_start <= 1'b1;
                memory_i_addr     <= pc;
                pc                <= pc + 32'd4;
            end
            if (reply) begin
                pending <= 1'b0;
                stale   <= 1'b0;
            end
            if (branch_taken) begin
                pc         <= branch_target;
                stale      <= memory_inst_start || (pending && !memory_inst_valid);
                skid_valid <= 1'b0;
            end else if (fresh && stall) begin
                skid_valid <= 1'b1;
            end else if (!stall) begin
                skid_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fresh && stall) begin
            skid_inst <= memory_inst;
        end
    end

endmodule

// ==== verilog/decode_stage.sv ====
module decode_stage (
    input  core_pkg::if_id_t   id_reg,
    input  core_pkg::regfile_t regfile,
    input  core_pkg::ctrl_t    exe_ctrl,
    input  core_pkg::ctrl_t    mem_ctrl,
    input  core_pkg::ctrl_t    wb_ctrl,
    input  logic               exe_valid,
    input  logic               mem_valid,
    input  logic               wb_valid,
    output core_pkg::id_exe_t  id_exe,
    output logic               hazard_stall
);
    import core_pkg::*;

    word_t     inst;
    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm_i;
    word_t     imm_s;
    word_t     imm_b;
    word_t     imm_u;
    word_t     imm_j;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     op2;
    ctrl_t     ctrl;
    logic      uses_rs1;
    logic      uses_rs2;
    logic      raw_rs1;
    logic      raw_rs2;

    function automatic logic writes_reg(logic valid, ctrl_t c, reg_addr_t r);
        return valid && c.rf_wen && c.wb_addr == r && r != '0;
    endfunction

    assign inst   = id_reg.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // x0 reads as zero
    assign rs1_data = (rs1 == '0) ? '0 : regfile[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regfile[rs2];

    always_comb begin
        ctrl = '{alu_fn: ALU_ADD, br_fn: BR_X, mem_fn: MEN_X, wb_sel: WB_ALU,
                 rf_wen: 1'b0, wb_addr: rd, is_exit: 1'b0};
        op2      = imm_i;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (opcode)
            op_reg: begin
                ctrl.rf_wen = 1'b1;
                uses_rs1    = 1'b1;
                uses_rs2    = 1'b1;
                op2         = rs2_data;
                case ({inst[30], funct3})
                    4'b0_000: ctrl.alu_fn = ALU_ADD;
                    4'b1_000: ctrl.alu_fn = ALU_SUB;
                    4'b0_111: ctrl.alu_fn = ALU_AND;
                    4'b0_110: ctrl.alu_fn = ALU_OR;
                    4'b0_100: ctrl.alu_fn = ALU_XOR;
                    default:  ctrl.rf_wen = 1'b0;
                endcase
            end
            op_imm: begin
                // addi only
                ctrl.rf_wen = (funct3 == 3'b000);
                uses_rs1    = 1'b1;
            end
            op_lui: begin
                ctrl.alu_fn = ALU_COPY2;
                ctrl.rf_wen = 1'b1;
                op2         = imm_u;
            end
            op_load: begin
                ctrl.mem_fn = MEN_LW;
                ctrl.wb_sel = WB_MEM;
                ctrl.rf_wen = 1'b1;
                uses_rs1    = 1'b1;
            end
            op_store: begin
                ctrl.mem_fn = MEN_SW;
                uses_rs1    = 1'b1;
                uses_rs2    = 1'b1;
                op2         = imm_s;
            end
            op_branch: begin
                if (funct3 == 3'b000) begin
                    ctrl.br_fn = BR_BEQ;
                end else if (funct3 == 3'b001) begin
                    ctrl.br_fn = BR_BNE;
                end
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                op2      = imm_b;
            end
            op_jal: begin
                ctrl.br_fn  = BR_JAL;
                ctrl.wb_sel = WB_PC4;
                ctrl.rf_wen = 1'b1;
                op2         = imm_j;
            end
            op_system: ctrl.is_exit = (inst[31:7] == '0);
            default: ;
        endcase
    end

    // the register file is written at the end of wb, so wb counts as in flight
    assign raw_rs1 = uses_rs1 && (writes_reg(exe_valid, exe_ctrl, rs1) ||
                                  writes_reg(mem_valid, mem_ctrl, rs1) ||
                                  writes_reg(wb_valid, wb_ctrl, rs1));
    assign raw_rs2 = uses_rs2 && (writes_reg(exe_valid, exe_ctrl, rs2) ||
                                  writes_reg(mem_valid, mem_ctrl, rs2) ||
                                  writes_reg(wb_valid, wb_ctrl, rs2));
    assign hazard_stall = id_reg.valid && (raw_rs1 || raw_rs2);

    always_comb begin
        id_exe.valid    = id_reg.valid && !hazard_stall;
        id_exe.pc       = id_reg.pc;
        id_exe.ctrl     = ctrl;
        id_exe.op1      = rs1_data;
        id_exe.op2      = op2;
        id_exe.rs2_data = rs2_data;
    end

endmodule

// ==== verilog/execute_stage.sv ====
module execute_stage (
    input  core_pkg::id_exe_t  exe_reg,
    output core_pkg::exe_mem_t exe_mem,
    output logic               branch_taken,
    output core_pkg::word_t    branch_target
);
    import core_pkg::*;

    word_t alu_out;
    logic  cond;

    always_comb begin
        case (exe_reg.ctrl.alu_fn)
            ALU_ADD:   alu_out = exe_reg.op1 + exe_reg.op2;
            ALU_SUB:   alu_out = exe_reg.op1 - exe_reg.op2;
            ALU_AND:   alu_out = exe_reg.op1 & exe_reg.op2;
            ALU_OR:    alu_out = exe_reg.op1 | exe_reg.op2;
            ALU_XOR:   alu_out = exe_reg.op1 ^ exe_reg.op2;
            ALU_COPY2: alu_out = exe_reg.op2;
            default:   alu_out = exe_reg.op1 + exe_reg.op2;
        endcase
    end

    // branches compare rs1 with rs2, op2 carries the offset
    always_comb begin
        case (exe_reg.ctrl.br_fn)
            BR_BEQ:  cond = (exe_reg.op1 == exe_reg.rs2_data);
            BR_BNE:  cond = (exe_reg.op1 != exe_reg.rs2_data);
            BR_JAL:  cond = 1'b1;
            default: cond = 1'b0;
        endcase
    end

    assign branch_taken  = exe_reg.valid && cond;
    assign branch_target = exe_reg.pc + exe_reg.op2;

    always_comb begin
        exe_mem.valid    = exe_reg.valid;
        exe_mem.pc       = exe_reg.pc;
        exe_mem.ctrl     = exe_reg.ctrl;
        exe_mem.alu_out  = alu_out;
        exe_mem.rs2_data = exe_reg.rs2_data;
    end

endmodule

// ==== verilog/memory_stage.sv ====
module memory_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  core_pkg::exe_mem_t mem_reg,
    output logic               memory_d_cmd_start,
    output logic               memory_d_cmd_write,
    input  logic               memory_d_cmd_ready,
    output core_pkg::word_t    memory_d_addr,
    output core_pkg::word_t    memory_wdata,
    output core_pkg::word_t    memory_wmask,
    input  core_pkg::word_t    memory_rdata,
    input  logic               memory_rdata_valid,
    output core_pkg::mem_wb_t  mem_wb,
    output logic               memory_busy
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        MS_IDLE,
        MS_CMD,
        MS_WAIT_DATA
    } mem_state_t;

    mem_state_t state;
    logic       done;
    logic       mem_op;
    word_t      load_data;

    assign mem_op = mem_reg.valid && mem_reg.ctrl.mem_fn != MEN_X;
    // done marks the cycle the finished access leaves the stage
    assign memory_busy = mem_op && !done;

    assign memory_d_cmd_start = (state == MS_CMD);
    assign memory_d_cmd_write = (mem_reg.ctrl.mem_fn == MEN_SW);
    assign memory_d_addr      = mem_reg.alu_out;
    assign memory_wdata       = mem_reg.rs2_data;
    assign memory_wmask       = '1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= MS_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                MS_IDLE: begin
                    if (mem_op && !done) begin
                        state <= MS_CMD;
                    end
                end
                MS_CMD: begin
                    if (memory_d_cmd_ready) begin
                        // a store is finished once accepted
                        state <= memory_d_cmd_write ? MS_IDLE : MS_WAIT_DATA;
                        done  <= memory_d_cmd_write;
                    end
                end
                MS_WAIT_DATA: begin
                    if (memory_rdata_valid) begin
                        state <= MS_IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= MS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == MS_WAIT_DATA && memory_rdata_valid) begin
            load_data <= memory_rdata;
        end
    end

    always_comb begin
        mem_wb.valid     = mem_reg.valid && !memory_busy;
        mem_wb.pc        = mem_reg.pc;
        mem_wb.ctrl      = mem_reg.ctrl;
        mem_wb.alu_out   = mem_reg.alu_out;
        mem_wb.mem_rdata = load_data;
    end

endmodule

// ==== verilog/writeback_stage.sv ====
module writeback_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  core_pkg::mem_wb_t  wb_reg,
    output core_pkg::regfile_t regfile,
    output core_pkg::word_t    gp,
    output logic               exit
);
    import core_pkg::*;

    word_t wdata;

    always_comb begin
        case (wb_reg.ctrl.wb_sel)
            WB_MEM:  wdata = wb_reg.mem_rdata;
            WB_PC4:  wdata = wb_reg.pc + 32'd4;
            default: wdata = wb_reg.alu_out;
        endcase
    end

    always_ff @(posedge clk) begin
        if (wb_reg.valid && wb_reg.ctrl.rf_wen && wb_reg.ctrl.wb_addr != '0) begin
            regfile[wb_reg.ctrl.wb_addr] <= wdata;
        end
    end

    // sticky until reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exit <= 1'b0;
        end else if (wb_reg.valid && wb_reg.ctrl.is_exit) begin
            exit <= 1'b1;
        end
    end

    assign gp = regfile[3];

endmodule

// ==== verilog/core.sv ====
module core (
    input  logic            clk,
    input  logic            rst_n,
    output logic            memory_inst_start,
    input  logic            memory_inst_ready,
    output core_pkg::word_t memory_i_addr,
    input  core_pkg::word_t memory_inst,
    input  logic            memory_inst_valid,
    output logic            memory_d_cmd_start,
    output logic            memory_d_cmd_write,
    input  logic            memory_d_cmd_ready,
    output core_pkg::word_t memory_d_addr,
    output core_pkg::word_t memory_wdata,
    output core_pkg::word_t memory_wmask,
    input  core_pkg::word_t memory_rdata,
    input  logic            memory_rdata_valid,
    output logic            exit,
    output core_pkg::word_t gp
);
    import core_pkg::*;

    if_id_t   if_id;
    if_id_t   id_reg;
    id_exe_t  id_exe;
    id_exe_t  exe_reg;
    exe_mem_t exe_mem;
    exe_mem_t mem_reg;
    mem_wb_t  mem_wb;
    mem_wb_t  wb_reg;
    regfile_t regfile;
    word_t    branch_target;
    logic     branch_taken;
    logic     flush;
    logic     hazard_stall;
    logic     memory_busy;
    logic     mem_stall;
    logic     exe_stall;
    logic     id_stall;
    logic     if_stall;

    assign mem_stall = memory_busy;
    assign exe_stall = mem_stall;
    assign id_stall  = exe_stall || hazard_stall;
    assign if_stall  = id_stall;

    // a branch held in exe by a stall redirects once, when it moves on
    assign flush = branch_taken && !exe_stall;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            id_reg.valid <= 1'b0;
        end else if (!if_stall) begin
            id_reg <= if_id;
        end
    end

    // a hazard leaves a bubble here since decode drops its valid
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            exe_reg.valid <= 1'b0;
        end else if (!exe_stall) begin
            exe_reg <= id_exe;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_reg.valid <= 1'b0;
        end else if (!mem_stall) begin
            mem_reg <= exe_mem;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_reg.valid <= 1'b0;
        end else begin
            wb_reg <= mem_wb;
        end
    end

    fetch_stage fetch_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .memory_inst_start (memory_inst_start),
        .memory_inst_ready (memory_inst_ready),
        .memory_i_addr     (memory_i_addr),
        .memory_inst       (memory_inst),
        .memory_inst_valid (memory_inst_valid),
        .if_id             (if_id),
        .stall             (if_stall),
        .branch_taken      (flush),
        .branch_target     (branch_target),
        .halt              (exit)
    );

    decode_stage decode_i (
        .id_reg       (id_reg),
        .regfile      (regfile),
        .exe_ctrl     (exe_reg.ctrl),
        .mem_ctrl     (mem_reg.ctrl),
        .wb_ctrl      (wb_reg.ctrl),
        .exe_valid    (exe_reg.valid),
        .mem_valid    (mem_reg.valid),
        .wb_valid     (wb_reg.valid),
        .id_exe       (id_exe),
        .hazard_stall (hazard_stall)
    );

    execute_stage execute_i (
        .exe_reg       (exe_reg),
        .exe_mem       (exe_mem),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    memory_stage memory_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .mem_reg            (mem_reg),
        .memory_d_cmd_start (memory_d_cmd_start),
        .memory_d_cmd_write (memory_d_cmd_write),
        .memory_d_cmd_ready (memory_d_cmd_ready),
        .memory_d_addr      (memory_d_addr),
        .memory_wdata       (memory_wdata),
        .memory_wmask       (memory_wmask),
        .memory_rdata       (memory_rdata),
        .memory_rdata_valid (memory_rdata_valid),
        .mem_wb             (mem_wb),
        .memory_busy        (memory_busy)
    );

    writeback_stage writeback_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_reg  (wb_reg),
        .regfile (regfile),
        .gp      (gp),
        .exit    (exit)
    );

endmodule

// ==== bench/core_asserts.sv ====
module core_asserts (
    input logic            clk,
    input logic            rst_n,
    input logic            memory_inst_start,
    input logic            memory_inst_ready,
    input core_pkg::word_t memory_i_addr,
    input logic            memory_inst_valid,
    input logic            memory_d_cmd_start,
    input logic            memory_d_cmd_ready,
    input logic            memory_d_cmd_write,
    input core_pkg::word_t memory_d_addr,
    input logic            exit
);
    logic fetch_pending;

    // one fetch in flight from acceptance until its valid pulse
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_pending <= 1'b0;
        end else if (memory_inst_start && memory_inst_ready) begin
            fetch_pending <= 1'b1;
        end else if (memory_inst_valid) begin
            fetch_pending <= 1'b0;
        end
    end

    inst_hold: assert property (@(posedge clk) disable iff (!rst_n)
        memory_inst_start && !memory_inst_ready |=>
            memory_inst_start && $stable(memory_i_addr))
        else $error("fetch request dropped or changed before ready");

    inst_single: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(memory_inst_start) |-> !fetch_pending)
        else $error("fetch request issued while another is outstanding");

    data_hold: assert property (@(posedge clk) disable iff (!rst_n)
        memory_d_cmd_start && !memory_d_cmd_ready |=>
            memory_d_cmd_start && $stable(memory_d_addr) && $stable(memory_d_cmd_write))
        else $error("data command dropped or changed before ready");

    exit_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        exit |=> exit)
        else $error("exit fell after being set");

endmodule

bind core core_asserts asserts_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .memory_inst_start  (memory_inst_start),
    .memory_inst_ready  (memory_inst_ready),
    .memory_i_addr      (memory_i_addr),
    .memory_inst_valid  (memory_inst_valid),
    .memory_d_cmd_start (memory_d_cmd_start),
    .memory_d_cmd_ready (memory_d_cmd_ready),
    .memory_d_cmd_write (memory_d_cmd_write),
    .memory_d_addr      (memory_d_addr),
    .exit               (exit)
);

// ==== bench/core_tb.sv ====
module core_tb;
    import core_pkg::*;

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_t;

    localparam int PROG_LEN = 34;
    localparam int N_STORES = 9;
    localparam int RESET_CYCLES = 16;
    localparam int TIMEOUT = 40 * PROG_LEN + RESET_CYCLES;
    localparam word_t nop_word = 32'h0000_0013;
    localparam word_t final_gp = 32'd20;

    // stores in program order without the skipped ones
    localparam store_t expected [N_STORES] = '{
        '{32'h0000_0100, 32'd17},
        '{32'h0000_0104, 32'd7},
        '{32'h0000_0108, 32'd4},
        '{32'h0000_010c, 32'd13},
        '{32'h0000_0110, 32'd9},
        '{32'h0000_0114, 32'h1234_5000},
        '{32'h0000_0118, 32'd18},
        '{32'h0000_0120, 32'd12},
        '{32'h0000_0128, 32'd88}
    };

    logic  clk = 1'b0;
    logic  rst_n = 1'b0;
    logic  memory_inst_ready = 1'b0;
    word_t memory_inst = '0;
    logic  memory_inst_valid = 1'b0;
    logic  memory_d_cmd_ready = 1'b0;
    word_t memory_rdata = '0;
    logic  memory_rdata_valid = 1'b0;
    logic  memory_inst_start;
    word_t memory_i_addr;
    logic  memory_d_cmd_start;
    logic  memory_d_cmd_write;
    word_t memory_d_addr;
    word_t memory_wdata;
    word_t memory_wmask;
    logic  exit;
    word_t gp;

    word_t  program_words [PROG_LEN];
    word_t  dmem [256];
    store_t stores [$];
    word_t  rng = 32'hb4886726;
    logic   stray_fetch = 1'b0;
    int     mismatch_count = 0;
    int     failure_count = 0;
    int     cycles = 0;

    logic       i_busy;
    logic [1:0] i_delay;
    logic [1:0] i_wait;
    word_t      i_addr;
    logic       d_busy;
    logic [1:0] d_delay;
    logic [1:0] d_wait;
    word_t      d_addr;

    core dut_i (.*);

    always #5 clk = ~clk;

    function automatic word_t xorshift(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t r_type(input int funct7, input int funct3, input int rd,
                                     input int rs1, input int rs2);
        return {funct7[6:0], rs2[4:0], rs1[4:0], funct3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t i_type(input int opcode, input int funct3, input int rd,
                                     input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], funct3[2:0], rd[4:0], opcode[6:0]};
    endfunction

    // sw rs2, imm(rs1)
    function automatic word_t s_type(input int rs1, input int rs2, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_type(input int funct3, input int rs1, input int rs2,
                                     input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], funct3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic word_t u_type(input int rd, input int imm);
        return {imm[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic word_t j_type(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic compare(input word_t got, input word_t want, input string what);
        if (got !== want) begin
            mismatch_count++;
            $display("mismatch at time %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    initial begin
        program_words[0]  = i_type('h13, 0, 1, 0, 5);
        program_words[1]  = i_type('h13, 0, 2, 0, 12);
        program_words[2]  = r_type('h00, 0, 3, 1, 2);
        program_words[3]  = s_type(0, 3, 'h100);
        program_words[4]  = r_type('h20, 0, 4, 2, 1);
        program_words[5]  = s_type(0, 4, 'h104);
        program_words[6]  = r_type('h00, 7, 5, 1, 2);
        program_words[7]  = s_type(0, 5, 'h108);
        program_words[8]  = r_type('h00, 6, 6, 1, 2);
        program_words[9]  = s_type(0, 6, 'h10c);
        program_words[10] = r_type('h00, 4, 7, 1, 2);
        program_words[11] = s_type(0, 7, 'h110);
        program_words[12] = u_type(8, 'h12345);
        program_words[13] = s_type(0, 8, 'h114);
        // load back the first result, then use it right away
        program_words[14] = i_type('h03, 2, 9, 0, 'h100);
        program_words[15] = i_type('h13, 0, 9, 9, 1);
        program_words[16] = s_type(0, 9, 'h118);
        // taken beq skips the store at 0x11c
        program_words[17] = b_type(0, 1, 1, 8);
        program_words[18] = s_type(0, 1, 'h11c);
        program_words[19] = b_type(1, 1, 1, 8);
        program_words[20] = s_type(0, 2, 'h120);
        // jal links pc 88 into x10 and skips the store at 0x124
        program_words[21] = j_type(10, 8);
        program_words[22] = s_type(0, 1, 'h124);
        program_words[23] = s_type(0, 10, 'h128);
        program_words[24] = i_type('h13, 0, 3, 3, 3);
        program_words[25] = 32'h0000_0073;
        for (int i = 26; i < PROG_LEN; i++) begin
            program_words[i[5:0]] = nop_word;
        end
        // too far past the ecall to be fetched once exit halts fetch
        program_words[31] = s_type(0, 1, 'h12c);
        for (int i = 0; i < 256; i++) begin
            dmem[i[7:0]] = word_t'(i * 4) ^ 32'h3c5a_0000;
        end
    end

    always @(posedge clk) begin
        rng <= xorshift(rng);
    end

    // instruction memory with random ready and latency
    always @(posedge clk) begin
        memory_inst_valid <= 1'b0;
        if (!rst_n) begin
            memory_inst_ready <= 1'b0;
            i_busy            <= 1'b0;
            i_wait            <= 2'd0;
        end else begin
            if (i_busy && i_delay == 2'd0) begin
                memory_inst_valid <= 1'b1;
                i_busy            <= 1'b0;
                if (i_addr < word_t'(4 * PROG_LEN)) begin
                    memory_inst <= program_words[i_addr[7:2]];
                end else begin
                    memory_inst <= nop_word;
                    stray_fetch <= 1'b1;
                end
            end else if (i_busy) begin
                i_delay <= i_delay - 2'd1;
            end
            if (memory_inst_start && memory_inst_ready) begin
                memory_inst_ready <= 1'b0;
                i_wait            <= rng[3:2];
                i_busy            <= 1'b1;
                i_addr            <= memory_i_addr;
                i_delay           <= rng[1:0];
            end else if (i_wait != 2'd0) begin
                i_wait <= i_wait - 2'd1;
            end else begin
                memory_inst_ready <= 1'b1;
            end
        end
    end

    // data memory where stores land at acceptance
    always @(posedge clk) begin
        memory_rdata_valid <= 1'b0;
        if (!rst_n) begin
            memory_d_cmd_ready <= 1'b0;
            d_busy             <= 1'b0;
            d_wait             <= 2'd0;
        end else begin
            if (d_busy && d_delay == 2'd0) begin
                memory_rdata_valid <= 1'b1;
                memory_rdata       <= dmem[d_addr[9:2]];
                d_busy             <= 1'b0;
            end else if (d_busy) begin
                d_delay <= d_delay - 2'd1;
            end
            if (memory_d_cmd_start && memory_d_cmd_ready) begin
                memory_d_cmd_ready <= 1'b0;
                d_wait             <= rng[7:6];
                if (memory_d_cmd_write) begin
                    compare(memory_wmask, '1, "store write mask");
                    dmem[memory_d_addr[9:2]] <= memory_wdata;
                    stores.push_back({memory_d_addr, memory_wdata});
                end else begin
                    d_busy  <= 1'b1;
                    d_addr  <= memory_d_addr;
                    d_delay <= rng[5:4];
                end
            end else if (d_wait != 2'd0) begin
                d_wait <= d_wait - 2'd1;
            end else begin
                memory_d_cmd_ready <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT) begin
            $display("timeout: program did not finish within %0d cycles", TIMEOUT);
            $display("errors: %0d mismatches, %0d other failures", mismatch_count,
                     failure_count + 1);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        store_t got;
        int     stores_at_exit;
        repeat (RESET_CYCLES - 1) begin
            @(negedge clk);
            compare(word_t'({memory_inst_start, memory_d_cmd_start, exit}), '0,
                    "start or exit during reset");
        end
        @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < N_STORES; i++) begin
            while (stores.size() <= i) begin
                @(negedge clk);
            end
            got = stores[i];
            compare(got.addr, expected[i[3:0]].addr, "store address");
            compare(got.data, expected[i[3:0]].data, "store data");
        end
        while (!exit) begin
            @(negedge clk);
        end
        stores_at_exit = stores.size();
        repeat (40) @(negedge clk);
        compare(word_t'(stores.size()), word_t'(stores_at_exit), "stores after exit");
        compare(word_t'(stores.size()), word_t'(N_STORES), "store count");
        compare(gp, final_gp, "gp");
        compare(word_t'(exit), 32'd1, "exit");
        if (stray_fetch) begin
            failure_count++;
            $display("instruction fetched from outside the program");
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== files.f ====
verilog/core_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/writeback_stage.sv
verilog/core.sv
bench/core_asserts.sv
bench/core_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds and runs the core testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module core_tb -f files.f -o core_sim &&
./obj_dir/core_sim | tee /dev/stderr | grep -F '** PASS **' > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
